// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int CSR_NUM_W = 14;

    // Register numbers
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h0;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h1;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h5;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h6;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'hc;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h30;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE1  = 14'h31;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE2  = 14'h32;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE3  = 14'h33;

    // CRMD layout
    localparam int CRMD_PLV_LSB  = 0;   // 2 bits
    localparam int CRMD_IE_BIT   = 2;
    localparam int CRMD_DA_BIT   = 3;
    localparam int CRMD_PG_BIT   = 4;
    localparam int CRMD_DATF_LSB = 5;   // 2 bits
    localparam int CRMD_DATM_LSB = 7;   // 2 bits

    // PRMD layout
    localparam int PRMD_PPLV_LSB = 0;
    localparam int PRMD_PIE_BIT  = 2;

    // ESTAT layout, IS bits 12:2 are tied to zero here
    localparam int ESTAT_IS_LSB       = 0;
    localparam int ESTAT_ECODE_LSB    = 16;  // 6 bits
    localparam int ESTAT_ESUBCODE_LSB = 22;  // 9 bits

    // Software-writable bits
    localparam logic [31:0] CRMD_WMASK   = 32'h0000_01ff;
    localparam logic [31:0] PRMD_WMASK   = 32'h0000_0007;
    localparam logic [31:0] ESTAT_WMASK  = 32'h0000_0003;  // SWI 1:0 only
    localparam logic [31:0] EENTRY_WMASK = 32'hffff_ffc0;

    // Direct address mode out of reset
    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;

endpackage

`default_nettype wire

// File: wb_pkg.sv
`default_nettype none

package wb_pkg;

    localparam int OP_W = 3;

    // Writeback command opcodes
    localparam logic [OP_W-1:0] OP_CSRRD   = 3'd0;
    localparam logic [OP_W-1:0] OP_CSRWR   = 3'd1;
    localparam logic [OP_W-1:0] OP_CSRXCHG = 3'd2;
    localparam logic [OP_W-1:0] OP_EXCEPT  = 3'd3;
    localparam logic [OP_W-1:0] OP_ERTN    = 3'd4;

    localparam int PAYLOAD_W = 78;

    // One command word, two readings of it
    // csr view   : number, write mask, write value
    // ex view    : faulting pc and exception codes, upper bits unused
    typedef union packed {
        struct packed {
            logic [csr_pkg::CSR_NUM_W-1:0] num;
            logic [31:0]                   wmask;
            logic [31:0]                   wvalue;
        } csr;
        struct packed {
            logic [PAYLOAD_W-48:0] pad;       // 31 spare bits
            logic [31:0]           pc;
            logic [5:0]            ecode;
            logic [8:0]            esubcode;
        } ex;
    } wb_payload_u;

endpackage

`default_nettype wire

// File: csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0] csr_num,
    input  logic [31:0]                   csr_wmask,
    input  logic [31:0]                   csr_wvalue,
    input  logic                          wb_ex,
    input  logic                          ertn_flush,
    input  logic [5:0]                    wb_ecode,
    input  logic [8:0]                    wb_esubcode,
    input  logic [31:0]                   wb_pc,
    output logic [31:0]                   csr_rvalue,
    output logic [31:0]                   ex_entry,
    output logic [31:0]                   era
);

    import csr_pkg::*;

    // Old bits survive where either mask is clear
    function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                               input logic [31:0] allow,
                                               input logic [31:0] wmask,
                                               input logic [31:0] wvalue);
        logic [31:0] m;
        m = wmask & allow;
        return (m & wvalue) | (~m & old_word);
    endfunction

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic        crmd_da;
    logic        crmd_pg;
    logic [1:0]  crmd_datf;
    logic [1:0]  crmd_datm;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    logic [1:0]  estat_is;      // SWI only
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] era_q;
    logic [25:0] eentry_va;
    logic [31:0] save_q [0:3];

    logic [31:0] crmd_word;
    logic [31:0] prmd_word;
    logic [31:0] estat_word;
    logic [31:0] eentry_word;
    logic [31:0] crmd_next;
    logic [31:0] prmd_next;
    logic [31:0] estat_next;
    logic [31:0] eentry_next;
    logic [31:0] era_next;
    logic [3:0]  save_sel;

    always_comb begin
        crmd_word = '0;
        crmd_word[CRMD_PLV_LSB +: 2]  = crmd_plv;
        crmd_word[CRMD_IE_BIT]        = crmd_ie;
        crmd_word[CRMD_DA_BIT]        = crmd_da;
        crmd_word[CRMD_PG_BIT]        = crmd_pg;
        crmd_word[CRMD_DATF_LSB +: 2] = crmd_datf;
        crmd_word[CRMD_DATM_LSB +: 2] = crmd_datm;
        prmd_word = '0;
        prmd_word[PRMD_PPLV_LSB +: 2] = prmd_pplv;
        prmd_word[PRMD_PIE_BIT]       = prmd_pie;
        estat_word = '0;
        estat_word[ESTAT_IS_LSB +: 2]       = estat_is;
        estat_word[ESTAT_ECODE_LSB +: 6]    = estat_ecode;
        estat_word[ESTAT_ESUBCODE_LSB +: 9] = estat_esubcode;
    end

    assign eentry_word = {eentry_va, 6'b0};

    assign crmd_next   = merge_word(crmd_word, CRMD_WMASK, csr_wmask, csr_wvalue);
    assign prmd_next   = merge_word(prmd_word, PRMD_WMASK, csr_wmask, csr_wvalue);
    assign estat_next  = merge_word(estat_word, ESTAT_WMASK, csr_wmask, csr_wvalue);
    assign eentry_next = merge_word(eentry_word, EENTRY_WMASK, csr_wmask, csr_wvalue);
    assign era_next    = merge_word(era_q, '1, csr_wmask, csr_wvalue);

    assign save_sel = {csr_num == CSR_SAVE3, csr_num == CSR_SAVE2,
                       csr_num == CSR_SAVE1, csr_num == CSR_SAVE0};

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= CRMD_RESET[CRMD_PLV_LSB +: 2];
            crmd_ie   <= CRMD_RESET[CRMD_IE_BIT];
            crmd_da   <= CRMD_RESET[CRMD_DA_BIT];
            crmd_pg   <= CRMD_RESET[CRMD_PG_BIT];
            crmd_datf <= CRMD_RESET[CRMD_DATF_LSB +: 2];
            crmd_datm <= CRMD_RESET[CRMD_DATM_LSB +: 2];
        end else if (wb_ex) begin
            crmd_plv <= 2'b0;  // Kernel, interrupts off
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == CSR_CRMD) begin
            crmd_plv  <= crmd_next[CRMD_PLV_LSB +: 2];
            crmd_ie   <= crmd_next[CRMD_IE_BIT];
            crmd_da   <= crmd_next[CRMD_DA_BIT];
            crmd_pg   <= crmd_next[CRMD_PG_BIT];
            crmd_datf <= crmd_next[CRMD_DATF_LSB +: 2];
            crmd_datm <= crmd_next[CRMD_DATM_LSB +: 2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && csr_num == CSR_PRMD) begin
            prmd_pplv <= prmd_next[PRMD_PPLV_LSB +: 2];
            prmd_pie  <= prmd_next[PRMD_PIE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is       <= 2'b0;
            estat_ecode    <= 6'b0;
            estat_esubcode <= 9'b0;
        end else if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end else if (csr_we && csr_num == CSR_ESTAT) begin
            estat_is <= estat_next[ESTAT_IS_LSB +: 2];
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            era_q <= wb_pc;
        end else if (csr_we && csr_num == CSR_ERA) begin
            era_q <= era_next;
        end
        if (csr_we && csr_num == CSR_EENTRY) begin
            eentry_va <= eentry_next[31:6];
        end
        for (int i = 0; i < 4; i++) begin
            if (csr_we && save_sel[i]) begin
                save_q[i] <= merge_word(save_q[i], '1, csr_wmask, csr_wvalue);
            end
        end
    end

    always_comb begin
        case (csr_num)
            CSR_CRMD:   csr_rvalue = crmd_word;
            CSR_PRMD:   csr_rvalue = prmd_word;
            CSR_ESTAT:  csr_rvalue = estat_word;
            CSR_ERA:    csr_rvalue = era_q;
            CSR_EENTRY: csr_rvalue = eentry_word;
            CSR_SAVE0:  csr_rvalue = save_q[0];
            CSR_SAVE1:  csr_rvalue = save_q[1];
            CSR_SAVE2:  csr_rvalue = save_q[2];
            CSR_SAVE3:  csr_rvalue = save_q[3];
            default:    csr_rvalue = 32'b0;  // Unimplemented number
        endcase
    end

    assign ex_entry = eentry_word;
    assign era      = era_q;

endmodule

`default_nettype wire

// File: wb_csr_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_csr_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    input  logic [wb_pkg::OP_W-1:0]       cmd_op,
    input  wb_pkg::wb_payload_u           cmd_payload,
    output logic                          res_valid,
    input  logic                          res_ready,
    output logic [31:0]                   res_rdata,
    input  logic                          redirect_busy,
    output logic                          ex_fire,
    output logic                          ertn_fire,
    output logic                          csr_we,
    output logic [csr_pkg::CSR_NUM_W-1:0] csr_num,
    output logic [31:0]                   csr_wmask,
    output logic [31:0]                   csr_wvalue,
    output logic                          wb_ex,
    output logic                          ertn_flush,
    output logic [5:0]                    wb_ecode,
    output logic [8:0]                    wb_esubcode,
    output logic [31:0]                   wb_pc,
    input  logic [31:0]                   csr_rvalue
);

    import wb_pkg::*;

    logic fire;
    logic op_result;    // Produces a read value
    logic op_write;
    logic op_xchg;      // Mask taken from payload
    logic op_ex;
    logic op_ertn;

    always_comb begin
        op_result = 1'b0;
        op_write  = 1'b0;
        op_xchg   = 1'b0;
        op_ex     = 1'b0;
        op_ertn   = 1'b0;
        case (cmd_op)
            OP_CSRRD: begin
                op_result = 1'b1;
            end
            OP_CSRWR: begin
                op_result = 1'b1;
                op_write  = 1'b1;
            end
            OP_CSRXCHG: begin
                op_result = 1'b1;
                op_write  = 1'b1;
                op_xchg   = 1'b1;
            end
            OP_EXCEPT: op_ex   = 1'b1;
            OP_ERTN:   op_ertn = 1'b1;
            default:   op_result = 1'b1;  // Spare codes act as a plain read
        endcase
    end

    // Both slots must be free or emptying this cycle
    assign cmd_ready = (!res_valid || res_ready) && !redirect_busy;
    assign fire      = cmd_valid && cmd_ready;

    // CSR view of the payload
    assign csr_num    = cmd_payload.csr.num;
    assign csr_wvalue = cmd_payload.csr.wvalue;
    assign csr_wmask  = op_xchg ? cmd_payload.csr.wmask : '1;
    assign csr_we     = fire && op_write;

    // Exception view of the payload
    assign wb_pc       = cmd_payload.ex.pc;
    assign wb_ecode    = cmd_payload.ex.ecode;
    assign wb_esubcode = cmd_payload.ex.esubcode;
    assign wb_ex       = fire && op_ex;
    assign ertn_flush  = fire && op_ertn;

    assign ex_fire   = wb_ex;
    assign ertn_fire = ertn_flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (fire && op_result) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    // Old value, sampled before this edge's write lands
    always_ff @(posedge clk) begin
        if (fire && op_result) begin
            res_rdata <= csr_rvalue;
        end
    end

endmodule

`default_nettype wire

// File: redirect_unit.sv
`timescale 1ns/1ps
`default_nettype none

module redirect_unit (
    input  logic        clk,
    input  logic        reset,
    input  logic        ex_fire,
    input  logic        ertn_fire,
    input  logic [31:0] ex_entry,
    input  logic [31:0] era,
    output logic        redirect_busy,
    output logic        redirect_valid,
    input  logic        redirect_ready,
    output logic [31:0] redirect_pc
);

    // Stalled redirect blocks the next fire
    assign redirect_busy = redirect_valid && !redirect_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else if (ex_fire || ertn_fire) begin
            redirect_valid <= 1'b1;
        end else if (redirect_ready) begin
            redirect_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_fire) begin
            redirect_pc <= ex_entry;  // Trap vector
        end else if (ertn_fire) begin
            redirect_pc <= era;       // Back to the faulting pc
        end
    end

endmodule

`default_nettype wire

// File: csr_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module csr_subsystem (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  logic [wb_pkg::OP_W-1:0] cmd_op,
    input  wb_pkg::wb_payload_u     cmd_payload,
    output logic                    res_valid,
    input  logic                    res_ready,
    output logic [31:0]             res_rdata,
    output logic                    redirect_valid,
    input  logic                    redirect_ready,
    output logic [31:0]             redirect_pc
);

    import csr_pkg::*;

    logic                 csr_we;
    logic [CSR_NUM_W-1:0] csr_num;
    logic [31:0]          csr_wmask;
    logic [31:0]          csr_wvalue;
    logic                 wb_ex;
    logic                 ertn_flush;
    logic [5:0]           wb_ecode;
    logic [8:0]           wb_esubcode;
    logic [31:0]          wb_pc;
    logic [31:0]          csr_rvalue;
    logic [31:0]          ex_entry;
    logic [31:0]          era;
    logic                 ex_fire;
    logic                 ertn_fire;
    logic                 redirect_busy;

    wb_csr_stage u_stage (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd_op        (cmd_op),
        .cmd_payload   (cmd_payload),
        .res_valid     (res_valid),
        .res_ready     (res_ready),
        .res_rdata     (res_rdata),
        .redirect_busy (redirect_busy),
        .ex_fire       (ex_fire),
        .ertn_fire     (ertn_fire),
        .csr_we        (csr_we),
        .csr_num       (csr_num),
        .csr_wmask     (csr_wmask),
        .csr_wvalue    (csr_wvalue),
        .wb_ex         (wb_ex),
        .ertn_flush    (ertn_flush),
        .wb_ecode      (wb_ecode),
        .wb_esubcode   (wb_esubcode),
        .wb_pc         (wb_pc),
        .csr_rvalue    (csr_rvalue)
    );

    csr_regfile u_regfile (
        .clk         (clk),
        .reset       (reset),
        .csr_we      (csr_we),
        .csr_num     (csr_num),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry),
        .era         (era)
    );

    redirect_unit u_redirect (
        .clk            (clk),
        .reset          (reset),
        .ex_fire        (ex_fire),
        .ertn_fire      (ertn_fire),
        .ex_entry       (ex_entry),
        .era            (era),
        .redirect_busy  (redirect_busy),
        .redirect_valid (redirect_valid),
        .redirect_ready (redirect_ready),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// File: csr_properties.sv
`timescale 1ns/1ps
`default_nettype none

module csr_properties (
    input logic                    clk,
    input logic                    reset,
    input logic                    cmd_valid,
    input logic                    cmd_ready,
    input logic [wb_pkg::OP_W-1:0] cmd_op,
    input logic                    res_valid,
    input logic                    res_ready,
    input logic [31:0]             res_rdata,
    input logic                    redirect_valid,
    input logic                    redirect_ready,
    input logic [31:0]             redirect_pc
);

    import wb_pkg::*;

    int   err_count = 0;
    logic accept;
    logic accept_redir;  // Exception or return taken

    assign accept       = cmd_valid && cmd_ready;
    assign accept_redir = accept && (cmd_op == OP_EXCEPT || cmd_op == OP_ERTN);

    reset_idle: assert property (@(posedge clk)
        reset |=> !res_valid && !redirect_valid && cmd_ready)
        else begin err_count++; $error("outputs not idle after reset"); end

    res_hold: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable(res_rdata))
        else begin err_count++; $error("stalled result changed"); end

    redir_hold: assert property (@(posedge clk) disable iff (reset)
        redirect_valid && !redirect_ready |=> redirect_valid && $stable(redirect_pc))
        else begin err_count++; $error("stalled redirect changed"); end

    res_blocks_cmd: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |-> !cmd_ready)
        else begin err_count++; $error("command taken while result stalled"); end

    csr_one_output: assert property (@(posedge clk) disable iff (reset)
        accept && !accept_redir |=> res_valid && !redirect_valid)
        else begin err_count++; $error("CSR command did not yield exactly a result"); end

    redir_one_output: assert property (@(posedge clk) disable iff (reset)
        accept_redir |=> redirect_valid && !res_valid)
        else begin err_count++; $error("trap command did not yield exactly a redirect"); end

endmodule

bind csr_subsystem csr_properties u_props (.*);

`default_nettype wire

// File: csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_tb;

    import csr_pkg::*;
    import wb_pkg::*;

    localparam int TIMEOUT  = 200;  // Cycles per wait loop
    localparam int N_RANDOM = 400;

    logic                 clk;
    logic                 reset;
    logic                 cmd_valid;
    logic                 cmd_ready;
    logic [OP_W-1:0]      cmd_op;
    wb_payload_u          cmd_payload;
    logic                 res_valid;
    logic                 res_ready;
    logic [31:0]          res_rdata;
    logic                 redirect_valid;
    logic                 redirect_ready;
    logic [31:0]          redirect_pc;

    logic                 stall_en;
    logic [31:0]          res_q [$];
    logic [31:0]          redir_q [$];

    // Reference register state
    logic [31:0]          m_crmd;
    logic [31:0]          m_prmd;
    logic [31:0]          m_estat;
    logic [31:0]          m_era;
    logic [31:0]          m_eentry;
    logic [31:0]          m_save [0:3];

    csr_subsystem dut (
        .clk            (clk),
        .reset          (reset),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .cmd_op         (cmd_op),
        .cmd_payload    (cmd_payload),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_rdata      (res_rdata),
        .redirect_valid (redirect_valid),
        .redirect_ready (redirect_ready),
        .redirect_pc    (redirect_pc)
    );

    always #10 clk = ~clk;

    task automatic stop_run(input string msg, input bit wrong_value);
        if (wrong_value) begin
            $display("FAIL at %0t ns: %s", $time, msg);
        end else begin
            $display("Error at %0t ns: %s", $time, msg);
        end
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    function automatic logic [31:0] writable(input logic [CSR_NUM_W-1:0] num);
        case (num)
            CSR_CRMD:   return 32'h0000_01ff;
            CSR_PRMD:   return 32'h0000_0007;
            CSR_ESTAT:  return 32'h0000_0003;  // SWI only
            CSR_EENTRY: return 32'hffff_ffc0;
            CSR_ERA, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return '1;
            default:    return '0;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [CSR_NUM_W-1:0] num);
        case (num)
            CSR_CRMD:   return m_crmd;
            CSR_PRMD:   return m_prmd;
            CSR_ESTAT:  return m_estat;
            CSR_ERA:    return m_era;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0:  return m_save[0];
            CSR_SAVE1:  return m_save[1];
            CSR_SAVE2:  return m_save[2];
            CSR_SAVE3:  return m_save[3];
            default:    return 32'h0;
        endcase
    endfunction

    task automatic model_write(input logic [CSR_NUM_W-1:0] num, input logic [31:0] value);
        case (num)
            CSR_CRMD:   m_crmd = value;
            CSR_PRMD:   m_prmd = value;
            CSR_ESTAT:  m_estat = value;
            CSR_ERA:    m_era = value;
            CSR_EENTRY: m_eentry = value;
            CSR_SAVE0:  m_save[0] = value;
            CSR_SAVE1:  m_save[1] = value;
            CSR_SAVE2:  m_save[2] = value;
            CSR_SAVE3:  m_save[3] = value;
            default:    ;
        endcase
    endtask

    // Update the model for a command taken at the coming edge
    task automatic model_accept(input logic [OP_W-1:0] op, input wb_payload_u pl);
        logic [31:0] old;
        logic [31:0] m;
        old = model_read(pl.csr.num);
        m   = writable(pl.csr.num);
        if (op == OP_CSRXCHG) begin
            m = m & pl.csr.wmask;
        end
        case (op)
            OP_CSRRD: res_q.push_back(old);
            OP_CSRWR, OP_CSRXCHG: begin
                res_q.push_back(old);
                model_write(pl.csr.num, (m & pl.csr.wvalue) | (~m & old));
            end
            OP_EXCEPT: begin
                redir_q.push_back(m_eentry);
                m_prmd         = {29'b0, m_crmd[2:0]};  // PIE and PPLV
                m_crmd[2:0]    = 3'b0;
                m_estat[30:16] = {pl.ex.esubcode, pl.ex.ecode};
                m_era          = pl.ex.pc;
            end
            OP_ERTN: begin
                redir_q.push_back(m_era);
                m_crmd[2:0] = m_prmd[2:0];
            end
            default: ;
        endcase
    endtask

    task automatic drive_ready();
        if (stall_en) begin
            res_ready      = ($urandom_range(99) < 60);
            redirect_ready = ($urandom_range(99) < 60);
        end else begin
            res_ready      = 1'b1;
            redirect_ready = 1'b1;
        end
    endtask

    // Transfers decided here happen at the next rising edge
    task automatic observe_outputs();
        logic [31:0] exp;
        if (dut.u_props.err_count != 0) begin
            stop_run("a bound protocol assertion failed", 1'b0);
        end
        if (res_valid && res_ready) begin
            if (res_q.size() == 0) begin
                stop_run("result delivered with none outstanding", 1'b0);
            end else begin
                exp = res_q.pop_front();
                assert (res_rdata === exp)
                    else stop_run($sformatf("res_rdata %h, expected %h", res_rdata, exp), 1'b1);
            end
        end
        if (redirect_valid && redirect_ready) begin
            if (redir_q.size() == 0) begin
                stop_run("redirect delivered with none outstanding", 1'b0);
            end else begin
                exp = redir_q.pop_front();
                assert (redirect_pc === exp)
                    else stop_run($sformatf("redirect_pc %h, expected %h", redirect_pc, exp),
                                  1'b1);
            end
        end
    endtask

    task automatic send_cmd(input logic [OP_W-1:0] op, input wb_payload_u pl);
        int  waited;
        bit  taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(negedge clk);
            drive_ready();
            cmd_valid   = 1'b1;
            cmd_op      = op;
            cmd_payload = pl;
            #1;
            observe_outputs();
            if (cmd_ready) begin
                taken = 1'b1;
                model_accept(op, pl);
            end else if (++waited > TIMEOUT) begin
                stop_run("command was never accepted", 1'b0);
            end
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        drive_ready();
        cmd_valid = 1'b0;
        #1;
        observe_outputs();
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle_cycle();
        while (res_q.size() != 0 || redir_q.size() != 0 || res_valid || redirect_valid) begin
            if (++waited > TIMEOUT) begin
                stop_run("outstanding results or redirects never arrived", 1'b0);
            end
            idle_cycle();
        end
    endtask

    function automatic wb_payload_u csr_payload(input logic [CSR_NUM_W-1:0] num,
                                                input logic [31:0] wmask,
                                                input logic [31:0] wvalue);
        wb_payload_u pl;
        pl            = '0;
        pl.csr.num    = num;
        pl.csr.wmask  = wmask;
        pl.csr.wvalue = wvalue;
        return pl;
    endfunction

    function automatic wb_payload_u ex_payload(input logic [31:0] pc, input logic [5:0] ecode,
                                               input logic [8:0] esubcode);
        wb_payload_u pl;
        pl            = '0;
        pl.ex.pc       = pc;
        pl.ex.ecode    = ecode;
        pl.ex.esubcode = esubcode;
        return pl;
    endfunction

    initial begin
        logic [CSR_NUM_W-1:0] regs [0:9];
        logic [OP_W-1:0]      op;
        regs = '{CSR_CRMD, CSR_PRMD, CSR_ESTAT, CSR_ERA, CSR_EENTRY,
                 CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, 14'h3ff};
        void'($urandom(32'h3c11_5f44));
        clk            = 1'b0;
        reset          = 1'b1;
        cmd_valid      = 1'b0;
        cmd_op         = OP_CSRRD;
        cmd_payload    = '0;
        res_ready      = 1'b1;
        redirect_ready = 1'b1;
        stall_en       = 1'b0;
        m_crmd         = 32'h0000_0008;  // DA set
        m_prmd         = 32'h0;
        m_estat        = 32'h0;
        m_era          = 'x;             // No reset on these
        m_eentry       = {26'bx, 6'b0};
        for (int k = 0; k < 4; k++) begin
            m_save[k] = 'x;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        send_cmd(OP_CSRRD, csr_payload(CSR_CRMD, '0, '0));
        send_cmd(OP_CSRRD, csr_payload(CSR_PRMD, '0, '0));
        send_cmd(OP_CSRRD, csr_payload(CSR_ESTAT, '0, '0));

        // Plain writes and read-back, ESTAT keeps IS 12:2 at zero
        for (int k = 3; k < 9; k++) begin
            send_cmd(OP_CSRWR, csr_payload(regs[k], '0, $urandom));
            send_cmd(OP_CSRRD, csr_payload(regs[k], '0, '0));
        end
        send_cmd(OP_CSRWR, csr_payload(CSR_ESTAT, '0, 32'hffff_ffff));
        send_cmd(OP_CSRRD, csr_payload(CSR_ESTAT, '0, '0));

        for (int k = 0; k < 10; k++) begin
            send_cmd(OP_CSRXCHG, csr_payload(regs[k], $urandom, $urandom));
            send_cmd(OP_CSRRD, csr_payload(regs[k], '0, '0));
        end

        // Trap from PLV 3 with IE set, then return
        send_cmd(OP_CSRWR, csr_payload(CSR_CRMD, '0, 32'h0000_000f));
        send_cmd(OP_EXCEPT, ex_payload(32'h1c00_0a40, 6'h0b, 9'h101));
        send_cmd(OP_CSRRD, csr_payload(CSR_PRMD, '0, '0));
        send_cmd(OP_CSRRD, csr_payload(CSR_CRMD, '0, '0));
        send_cmd(OP_CSRRD, csr_payload(CSR_ESTAT, '0, '0));
        send_cmd(OP_CSRRD, csr_payload(CSR_ERA, '0, '0));
        send_cmd(OP_ERTN, csr_payload('0, '0, '0));
        send_cmd(OP_CSRRD, csr_payload(CSR_CRMD, '0, '0));
        drain();

        stall_en = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            op = OP_W'($urandom_range(4));
            if (op == OP_EXCEPT) begin
                send_cmd(op, ex_payload($urandom, 6'($urandom_range(63)),
                                        9'($urandom_range(511))));
            end else begin
                send_cmd(op, csr_payload(regs[$urandom_range(9)], $urandom, $urandom));
            end
        end
        drain();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
csr_pkg.sv
wb_pkg.sv
csr_regfile.sv
wb_csr_stage.sv
redirect_unit.sv
csr_subsystem.sv
csr_properties.sv
csr_tb.sv

// File: Bender.yml
package:
  name: csr_subsystem

sources:
  - files:
      - csr_pkg.sv
      - wb_pkg.sv
      - csr_regfile.sv
      - wb_csr_stage.sv
      - redirect_unit.sv
      - csr_subsystem.sv
  - target: test
    files:
      - csr_properties.sv
      - csr_tb.sv
